//--- project.f
+incdir+tb
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_wb_port.sv
logic/ex_stage.sv
tb/ex_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f project.f --top-module ex_tb -o ex_sim
if [ $? -ne 0 ]; then
  echo "run.sh: Verilator build failed"
  exit 1
fi

./obj_dir/ex_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "run.sh: simulation binary returned an error"
  exit 1
fi

cat sim.log
if grep -q "^sim passed$" sim.log; then
  exit 0
fi
echo "run.sh: testbench reported failure"
exit 1

//--- tb/ex_checks.svh
////////////////////////////////////////
// Typed compare tasks and error counters
// Included inside the testbench module
////////////////////////////////////////

`ifndef EX_CHECKS_SVH
`define EX_CHECKS_SVH

int word_errs  = 0;
int port_errs  = 0;
int bit_errs   = 0;
int other_errs = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp) begin
    word_errs++;
    $display("ERROR %s got %08h expected %08h at %0t", name, got, exp, $time);
  end
endtask

// All three fields of a write port at once
task automatic check_port(input string name, input wb_port_t got, input wb_port_t exp);
  if (got !== exp) begin
    port_errs++;
    $display("ERROR %s got we %0h addr %02h data %08h", name, got.we, got.addr, got.data);
    $display("ERROR %s expected we %0h addr %02h data %08h at %0t",
             name, exp.we, exp.addr, exp.data, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    bit_errs++;
    $display("ERROR %s got %0h expected %0h at %0t", name, got, exp, $time);
  end
endtask

// Failures that are not a wrong value
task automatic note_failure(input string what);
  other_errs++;
  $display("Failure at %0t: %s", $time, what);
endtask

`endif

//--- tb/ex_tb.sv
////////////////////////////////////////
// Testbench for the execute stage
// Xorshift stimulus checked against a local model
////////////////////////////////////////

`timescale 1ns/1ps

module ex_tb import ex_pkg::*; ();

  localparam int unsigned STEP_BITS  = 2;
  localparam int          WAIT_LIMIT = 64;
  // Step cycles of a high product
  localparam int          MULH_STEPS = 32 / STEP_BITS;

  // Signals carry the DUT port names
  logic        clk, rst_n;
  logic        alu_en_i, mult_en_i, csr_access_i;
  alu_req_t    alu_req_i;
  mult_req_t   mult_req_i;
  word_t       csr_rdata_i, lsu_rdata_i;
  logic        regfile_alu_we_i, regfile_we_i, lsu_en_i;
  reg_addr_t   regfile_alu_waddr_i, regfile_waddr_i;
  logic        lsu_ready_ex_i, branch_in_ex_i, wb_ready_i;
  wb_port_t    fw_port_o, wb_port_o;
  word_t       jump_target_o;
  logic        branch_decision_o, mult_multicycle_o, ex_ready_o, ex_valid_o;
  logic [31:0] rnd_state;

  `include "ex_checks.svh"

  ex_stage #(.MULT_STEP_BITS(STEP_BITS)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Model
  ////////////////////////////////////////

  // One xorshift32 step per call
  function automatic logic [31:0] next_rand();
    rnd_state ^= rnd_state << 13;
    rnd_state ^= rnd_state >> 17;
    rnd_state ^= rnd_state << 5;
    return rnd_state;
  endfunction

  function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  // Full 64-bit product with operands sign extended for MULH
  function automatic word_t mult_model(mult_op_e op, word_t a, word_t b);
    logic [63:0] prod;
    if (op == MULT_MULH) begin
      prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    end else begin
      prod = {32'b0, a} * {32'b0, b};
    end
    return (op == MULT_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic wb_port_t make_port(logic we, reg_addr_t addr, word_t data);
    return '{we: we, addr: addr, data: data};
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Drive point just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // Sample mid cycle where outputs have settled
  task automatic settle();
    #4;
  endtask

  task automatic drive_idle();
    alu_en_i            = 1'b0;
    alu_req_i           = '0;
    mult_en_i           = 1'b0;
    mult_req_i          = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    branch_in_ex_i      = 1'b0;
    wb_ready_i          = 1'b1;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  // ALU, branch outputs and forward priority against CSR and MUL
  task automatic alu_tests(input int count);
    logic [31:0] r;
    word_t       a, b, exp;
    for (int i = 0; i < count; i++) begin
      tick();
      drive_idle();
      r = next_rand();
      a = next_rand();
      b = r[4] ? a : next_rand();
      alu_en_i            = 1'b1;
      alu_req_i           = '{op: alu_op_e'(r[3:0]), a: a, b: b, c: next_rand()};
      regfile_alu_we_i    = r[5];
      regfile_alu_waddr_i = r[13:8];
      csr_access_i        = (r[19:16] == 4'd0);
      csr_rdata_i         = next_rand();
      mult_en_i           = (r[23:20] == 4'd0);
      mult_req_i          = '{op: MULT_MUL, a: b, b: a};
      settle();
      if (csr_access_i) begin
        exp = csr_rdata_i;
      end else if (mult_en_i) begin
        exp = mult_model(MULT_MUL, b, a);
      end else begin
        exp = alu_model(alu_req_i.op, a, b);
      end
      check_port("fw_port_o", fw_port_o, make_port(r[5], r[13:8], exp));
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      check_bit("ex_ready_o", ex_ready_o, 1'b1);
      check_word("jump_target_o", jump_target_o, alu_req_i.c);
      if (alu_req_i.op >= ALU_EQ) begin
        check_bit("branch_decision_o", branch_decision_o, cmp_model(alu_req_i.op, a, b));
      end
    end
  endtask

  task automatic mult_tests(input int count);
    logic [31:0] r;
    mult_op_e    op;
    word_t       a, b;
    int          cycles;
    for (int i = 0; i < count; i++) begin
      tick();
      drive_idle();
      r  = next_rand();
      op = (r[1:0] == 2'd0) ? MULT_MUL : (r[1] ? MULT_MULHU : MULT_MULH);
      a  = next_rand();
      b  = next_rand();
      mult_en_i           = 1'b1;
      mult_req_i          = '{op: op, a: a, b: b};
      regfile_alu_we_i    = 1'b1;
      regfile_alu_waddr_i = r[13:8];
      settle();
      if (op == MULT_MUL) begin
        check_bit("ex_ready_o", ex_ready_o, 1'b1);
        check_bit("ex_valid_o", ex_valid_o, 1'b1);
      end else begin
        check_bit("ex_ready_o", ex_ready_o, 1'b0);
        check_bit("mult_multicycle_o", mult_multicycle_o, 1'b1);
        cycles = 0;
        while (!ex_valid_o && cycles < WAIT_LIMIT) begin
          tick();
          // A WB stall in the done cycle must hold the result one more cycle
          wb_ready_i = ~(r[2] & (cycles == MULH_STEPS));
          settle();
          cycles++;
        end
        if (!ex_valid_o) begin
          note_failure("EX valid never rose after a high multiply");
        end else if (cycles != MULH_STEPS + 1 + r[2]) begin
          note_failure("high multiply result came on the wrong cycle");
        end
      end
      check_port("fw_port_o", fw_port_o, make_port(1'b1, r[13:8], mult_model(op, a, b)));
    end
    tick();
    drive_idle();
    settle();
    check_bit("mult_multicycle_o", mult_multicycle_o, 1'b0);
  endtask

  // Load a write into EX/WB, then either drain it or stall on it
  task automatic wb_tests(input int count);
    logic [31:0] r;
    word_t       ldata;
    logic        stall_lsu;
    for (int i = 0; i < count; i++) begin
      tick();
      drive_idle();
      r = next_rand();
      lsu_en_i        = 1'b1;
      regfile_we_i    = 1'b1;
      regfile_waddr_i = r[5:0];
      settle();
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
      tick();
      drive_idle();
      ldata       = next_rand();
      lsu_rdata_i = ldata;
      if (r[6]) begin
        // Stall with a new write pending behind it
        stall_lsu       = r[7];
        alu_en_i        = 1'b1;
        lsu_en_i        = 1'b1;
        regfile_we_i    = 1'b1;
        regfile_waddr_i = ~r[5:0];
        lsu_ready_ex_i  = ~stall_lsu;
        wb_ready_i      = stall_lsu ? r[8] : 1'b0;
        branch_in_ex_i  = r[9];
      end
      settle();
      check_port("wb_port_o", wb_port_o, make_port(1'b1, r[5:0], ldata));
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
      check_bit("ex_ready_o", ex_ready_o, r[6] ? r[9] : 1'b1);
      tick();
      settle();
      check_port("wb_port_o", wb_port_o, make_port(~wb_ready_i, r[5:0], ldata));
    end
  endtask

  initial begin
    drive_idle();
    rst_n     = 1'b0;
    rnd_state = 32'had8e_d49e;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    settle();
    check_bit("wb_port_o.we", wb_port_o.we, 1'b0);
    check_bit("mult_multicycle_o", mult_multicycle_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, 1'b1);
    alu_tests(400);
    mult_tests(40);
    wb_tests(60);
    tick();
    drive_idle();
    $display("Errors: word %0d, port %0d, bit %0d, other %0d",
             word_errs, port_errs, bit_errs, other_errs);
    if (word_errs + port_errs + bit_errs + other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- logic/ex_stage.sv
////////////////////////////////////////
// Execute stage top, ALU, multiplier and write ports
// Forms the stall handshake levels and branch outputs
////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
  parameter int unsigned MULT_STEP_BITS = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  // ALU and multiplier requests
  input  logic      alu_en_i,
  input  alu_req_t  alu_req_i,
  input  logic      mult_en_i,
  input  mult_req_t mult_req_i,
  // CSR access
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  // Forward port write from ID
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  // Load/store write, delayed to WB
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,
  output wb_port_t  fw_port_o,
  output wb_port_t  wb_port_o,
  output word_t     jump_target_o,
  output logic      branch_decision_o,
  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;
  logic  mult_ready;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  ex_alu u_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult #(
    .MULT_STEP_BITS (MULT_STEP_BITS)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_port u_wb_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_en_i      (alu_en_i),
    .mult_en_i     (mult_en_i),
    .csr_access_i  (csr_access_i),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .alu_we_i      (regfile_alu_we_i),
    .lsu_we_i      (regfile_we_i),
    .alu_waddr_i   (regfile_alu_waddr_i),
    .lsu_waddr_i   (regfile_waddr_i),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  ////////////////////////////////////////
  // Branch and stall
  ////////////////////////////////////////

  // Branch resolves in EX, target is operand c
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_req_i.c;

  // A branch finishes without the WB stage
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  // Valid does not depend on ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                    & (mult_ready & lsu_ready_ex_i & wb_ready_i);

endmodule

//--- logic/ex_wb_port.sv
////////////////////////////////////////
// Register file write ports of the execute stage
// Forward mux, EX/WB register and load/store port
////////////////////////////////////////

`timescale 1ns/1ps

module ex_wb_port import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  word_t     lsu_rdata_i,
  input  logic      alu_we_i,
  input  logic      lsu_we_i,
  input  reg_addr_t alu_waddr_i,
  input  reg_addr_t lsu_waddr_i,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,
  output wb_port_t  fw_port_o,
  output wb_port_t  wb_port_o
);

  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  ////////////////////////////////////////
  // Forward port
  ////////////////////////////////////////

  always_comb begin
    fw_port_o.we   = alu_we_i;
    fw_port_o.addr = alu_waddr_i;
    // CSR wins, then multiplier, then ALU
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_result_i;
    end else begin
      fw_port_o.data = '0;
    end
  end

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      // Valid already includes WB ready
      lsu_we_q <= lsu_we_i;
      if (lsu_we_i) begin
        lsu_waddr_q <= lsu_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Empty slot moves on, drop the old write
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives in the WB cycle
  assign wb_port_o = '{we: lsu_we_q, addr: lsu_waddr_q, data: lsu_rdata_i};

endmodule

//--- logic/ex_mult.sv
////////////////////////////////////////
// Multiplier, MUL in one cycle
// MULH and MULHU by shift-add, MULT_STEP_BITS per cycle
////////////////////////////////////////

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; #(
  parameter int unsigned MULT_STEP_BITS = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  mult_req_t req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  localparam int unsigned NUM_STEPS = 32 / MULT_STEP_BITS;
  localparam logic [5:0]  LAST_CNT  = 6'(NUM_STEPS - 1);

  typedef enum logic [1:0] {IDLE, STEP, DONE} mult_state_e;

  mult_state_e               state_q;
  mult_state_e               state_d;
  logic [5:0]                cnt_q;
  logic [63:0]               acc_q;
  logic [63:0]               mcand_q;
  word_t                     mplier_q;
  logic                      neg_q;
  logic                      start;
  logic                      a_neg;
  logic                      b_neg;
  word_t                     a_mag;
  word_t                     b_mag;
  logic [MULT_STEP_BITS-1:0] digit;
  logic [63:0]               step_prod;
  logic [63:0]               prod_fix;
  word_t                     lo_prod;

  // Low word is the same for signed and unsigned operands
  assign lo_prod = req_i.a * req_i.b;

  // A high product starts only from idle
  assign start = enable_i & (state_q == IDLE) & (req_i.op != MULT_MUL);

  // Magnitudes so the loop stays unsigned
  assign a_neg = (req_i.op == MULT_MULH) & req_i.a[31];
  assign b_neg = (req_i.op == MULT_MULH) & req_i.b[31];
  assign a_mag = a_neg ? -req_i.a : req_i.a;
  assign b_mag = b_neg ? -req_i.b : req_i.b;

  ////////////////////////////////////////
  // Shift-add loop
  ////////////////////////////////////////

  assign digit     = mplier_q[MULT_STEP_BITS-1:0];
  assign step_prod = mcand_q * 64'(digit);

  always_ff @(posedge clk) begin
    if (start) begin
      acc_q    <= '0;
      mcand_q  <= {32'b0, a_mag};
      mplier_q <= b_mag;
      neg_q    <= a_neg ^ b_neg;
    end else if (state_q == STEP) begin
      acc_q    <= acc_q + step_prod;
      mcand_q  <= mcand_q << MULT_STEP_BITS;
      mplier_q <= mplier_q >> MULT_STEP_BITS;
    end
  end

  ////////////////////////////////////////
  // FSM and step counter
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start) state_d = STEP;
      STEP: if (cnt_q == 6'd0) state_d = DONE;
      // Hold the result until the stage moves on
      DONE: if (ex_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        cnt_q <= LAST_CNT;
      end else if (state_q == STEP) begin
        cnt_q <= cnt_q - 6'd1;
      end
    end
  end

  // Sign fix-up of the full product
  assign prod_fix = neg_q ? -acc_q : acc_q;

  assign result_o     = (state_q == DONE) ? prod_fix[63:32] : lo_prod;
  assign ready_o      = ~start & (state_q != STEP);
  assign multicycle_o = start | (state_q != IDLE);

endmodule

//--- logic/ex_alu.sv
////////////////////////////////////////
// Combinational ALU of the execute stage
// Result and comparison flag in the request cycle
////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  alu_req_t req_i,
  output word_t    result_o,
  output logic     cmp_result_o
);

  word_t      add_res;
  word_t      sub_res;
  word_t      sll_res;
  word_t      srl_res;
  word_t      sra_res;
  logic [4:0] shamt;
  logic       is_eq;
  logic       lt_s;
  logic       lt_u;
  logic       cmp_flag;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Shift amount from the low five bits of b
  assign shamt = req_i.b[4:0];

  assign add_res = req_i.a + req_i.b;
  assign sub_res = req_i.a - req_i.b;
  assign sll_res = req_i.a << shamt;
  assign srl_res = req_i.a >> shamt;
  // Arithmetic shift keeps the sign of a
  assign sra_res = word_t'($signed(req_i.a) >>> shamt);

  // Shared compare terms for SLT and branches
  assign is_eq = (req_i.a == req_i.b);
  assign lt_s  = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u  = (req_i.a < req_i.b);

  ////////////////////////////////////////
  // Comparison flag
  ////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_SLT:  cmp_flag = lt_s;
      ALU_SLTU: cmp_flag = lt_u;
      ALU_EQ:   cmp_flag = is_eq;
      ALU_NE:   cmp_flag = ~is_eq;
      ALU_LT:   cmp_flag = lt_s;
      ALU_GE:   cmp_flag = ~lt_s;
      ALU_LTU:  cmp_flag = lt_u;
      ALU_GEU:  cmp_flag = ~lt_u;
      // Not a compare, no branch taken
      default:  cmp_flag = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp_flag;

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_ADD: result_o = add_res;
      ALU_SUB: result_o = sub_res;
      ALU_AND: result_o = req_i.a & req_i.b;
      ALU_OR:  result_o = req_i.a | req_i.b;
      ALU_XOR: result_o = req_i.a ^ req_i.b;
      ALU_SLL: result_o = sll_res;
      ALU_SRL: result_o = srl_res;
      ALU_SRA: result_o = sra_res;
      // Compares return the flag in bit 0
      default: result_o = {31'b0, cmp_flag};
    endcase
  end

endmodule

//--- logic/ex_pkg.sv
////////////////////////////////////////
// Shared types for the execute stage
// Import with ex_pkg::* in the module header
////////////////////////////////////////

package ex_pkg;

  // Data word for operands, results, CSR and load data
  typedef logic [31:0] word_t;

  // Register file address, 64 entries
  typedef logic [5:0] reg_addr_t;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // ALU operations, comparisons at the end
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Multiplier operations
  // MUL is single cycle, the high products are iterative
  typedef enum logic [1:0] {
    MULT_MUL, MULT_MULH, MULT_MULHU
  } mult_op_e;

  ////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////

  // Operand c carries the jump target
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  typedef struct packed {
    mult_op_e op;
    word_t    a;
    word_t    b;
  } mult_req_t;

  // One register file write
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } wb_port_t;

endpackage
